//--- fetch_seq.sv
`include "render_cfg.svh"

module fetch_seq (
    input  logic                      clk,
    input  logic                      rst,
    input  render_pkg::layer_cfg_t    cfg,
    input  logic                      line_start,

    // Bus master
    output logic [`RENDER_ADDR_W-1:0] bus_addr,
    output logic                      bus_strobe,
    input  logic [`RENDER_DATA_W-1:0] bus_rddata,
    input  logic                      bus_ack,

    // Address stages
    input  logic [`RENDER_ADDR_W-1:0] map_addr,
    input  logic                      col_odd,
    input  logic [`RENDER_ADDR_W-1:0] tile_addr,
    input  render_pkg::map_entry_t    entry,
    output logic [7:0]                htile_cnt,
    output logic                      word_cnt,
    output logic [`RENDER_DATA_W-1:0] map_word,

    // Pixel stage
    output logic                      render_start,
    output render_pkg::render_word_t  render_word,
    input  logic                      busy,
    input  logic                      line_done
);

    import render_pkg::*;

    fetch_state_e state;
    logic         strobe_r;
    logic         last_word;        // Final word of the tile row
    render_word_t pending;          // Fetched, not yet handed over

    assign bus_strobe = strobe_r && !bus_ack;
    assign last_word  = (cfg.depth != DEPTH_8BPP) || word_cnt;

    ///////////////////////////////
    // Sequencer
    ///////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= WAIT_START;
            strobe_r     <= 1'b0;
            htile_cnt    <= '0;
            word_cnt     <= 1'b0;
            render_start <= 1'b0;
        end else begin
            render_start <= 1'b0;

            case (state)
                FETCH_MAP: begin
                    strobe_r <= 1'b1;
                    state    <= WAIT_MAP;
                end
                WAIT_MAP: begin
                    if (bus_ack) begin
                        strobe_r <= 1'b0;
                        state    <= FETCH_TILE;
                    end
                end
                FETCH_TILE: begin
                    strobe_r <= 1'b1;
                    state    <= WAIT_TILE;
                end
                WAIT_TILE: begin
                    if (bus_ack) begin
                        strobe_r <= 1'b0;
                        state    <= RENDER;
                    end
                end
                RENDER: begin
                    if (line_done) begin
                        state <= WAIT_START;
                    end else if (!busy) begin
                        render_start <= 1'b1;
                        if (last_word) begin
                            word_cnt  <= 1'b0;
                            htile_cnt <= htile_cnt + 8'd1;
                            state     <= col_odd ? FETCH_MAP : FETCH_TILE;
                        end else begin
                            word_cnt <= 1'b1;
                            state    <= FETCH_TILE;
                        end
                    end
                end
                default: state <= WAIT_START;     // Idle until line start
            endcase

            // Restart wins over everything, a pending transfer is abandoned
            if (line_start) begin
                state        <= FETCH_MAP;
                strobe_r     <= 1'b0;
                htile_cnt    <= '0;
                word_cnt     <= 1'b0;
                render_start <= 1'b0;
            end
        end
    end

    // Address and data registers
    always_ff @(posedge clk) begin
        case (state)
            FETCH_MAP:  bus_addr <= map_addr;
            FETCH_TILE: bus_addr <= tile_addr;
            WAIT_MAP: begin
                if (bus_ack) map_word <= bus_rddata;
            end
            WAIT_TILE: begin
                if (bus_ack) begin
                    pending <= '{pixels: bus_rddata, pal_offset: entry.pal_offset,
                                 hflip: entry.hflip};
                end
            end
            RENDER: begin
                if (!busy && !line_done) render_word <= pending;
            end
            default: ;
        endcase
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        bus_strobe |=> $stable(bus_addr))
        else $error("bus_addr changed while strobe pending");

    // Pixel stage must be free for every handover
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        render_start |-> !busy)
        else $error("render_start while pixel stage busy");

endmodule

//--- layer_renderer.sv
`include "render_cfg.svh"

module layer_renderer (
    input  logic                        clk,
    input  logic                        rst,
    input  render_pkg::layer_cfg_t      cfg,

    // Composer
    input  logic [8:0]                  line_idx,
    input  logic                        line_start,

    // Bus master
    output logic [`RENDER_ADDR_W-1:0]   bus_addr,
    output logic                        bus_strobe,
    input  logic [`RENDER_DATA_W-1:0]   bus_rddata,
    input  logic                        bus_ack,

    // Line buffer
    output logic                        lb_wren,
    output logic [`RENDER_LB_IDX_W-1:0] lb_wridx,
    output logic [7:0]                  lb_wrdata
);

    import render_pkg::*;

    logic [`RENDER_ADDR_W-1:0] map_addr;
    logic                      map_half;
    logic [2:0]                tile_row;
    logic                      col_odd;
    logic [7:0]                htile_cnt;
    logic                      word_cnt;
    logic [`RENDER_DATA_W-1:0] map_word;
    map_entry_t                entry;
    logic [`RENDER_ADDR_W-1:0] tile_addr;
    logic                      render_start;
    render_word_t              render_word;
    logic                      busy;
    logic                      line_done;

    ///////////////////////////////
    // Address stages
    ///////////////////////////////

    map_addr_calc u_map_addr (
        .cfg       (cfg),
        .line_idx  (line_idx),
        .htile_cnt (htile_cnt),
        .map_addr  (map_addr),
        .map_half  (map_half),
        .tile_row  (tile_row),
        .col_odd   (col_odd)
    );

    tile_addr_calc u_tile_addr (
        .cfg       (cfg),
        .map_word  (map_word),
        .map_half  (map_half),
        .tile_row  (tile_row),
        .word_cnt  (word_cnt),
        .entry     (entry),
        .tile_addr (tile_addr)
    );

    fetch_seq u_fetch (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .line_start   (line_start),
        .bus_addr     (bus_addr),
        .bus_strobe   (bus_strobe),
        .bus_rddata   (bus_rddata),
        .bus_ack      (bus_ack),
        .map_addr     (map_addr),
        .col_odd      (col_odd),
        .tile_addr    (tile_addr),
        .entry        (entry),
        .htile_cnt    (htile_cnt),
        .word_cnt     (word_cnt),
        .map_word     (map_word),
        .render_start (render_start),
        .render_word  (render_word),
        .busy         (busy),
        .line_done    (line_done)
    );

    pixel_emit u_pixel (
        .clk          (clk),
        .rst          (rst),
        .cfg          (cfg),
        .line_start   (line_start),
        .render_start (render_start),
        .render_word  (render_word),
        .busy         (busy),
        .line_done    (line_done),
        .lb_wren      (lb_wren),
        .lb_wridx     (lb_wridx),
        .lb_wrdata    (lb_wrdata)
    );

endmodule

//--- map_addr_calc.sv
`include "render_cfg.svh"

module map_addr_calc (
    input  render_pkg::layer_cfg_t    cfg,
    input  logic [8:0]                line_idx,
    input  logic [7:0]                htile_cnt,
    output logic [`RENDER_ADDR_W-1:0] map_addr,
    output logic                      map_half,
    output logic [2:0]                tile_row,
    output logic                      col_odd
);

    logic [11:0] scrolled_line;
    logic [7:0]  vmap_idx;       // Tile row before wrap
    logic [7:0]  vmap_wrapped;
    logic [7:0]  hmap_idx;       // Tile column, wraps below
    logic [15:0] map_idx;

    assign scrolled_line = {3'b000, line_idx} + cfg.vscroll;
    assign vmap_idx      = scrolled_line[10:3];
    assign hmap_idx      = htile_cnt + cfg.hscroll[10:3];

    always_comb begin
        unique case (cfg.map_height)
            `RENDER_MAP_32:  vmap_wrapped = {3'b000, vmap_idx[4:0]};
            `RENDER_MAP_64:  vmap_wrapped = {2'b00, vmap_idx[5:0]};
            `RENDER_MAP_128: vmap_wrapped = {1'b0, vmap_idx[6:0]};
            `RENDER_MAP_256: vmap_wrapped = vmap_idx;
        endcase
    end

    // Row times width plus wrapped column
    always_comb begin
        unique case (cfg.map_width)
            `RENDER_MAP_32:  map_idx = {3'b000, vmap_wrapped, hmap_idx[4:0]};
            `RENDER_MAP_64:  map_idx = {2'b00, vmap_wrapped, hmap_idx[5:0]};
            `RENDER_MAP_128: map_idx = {1'b0, vmap_wrapped, hmap_idx[6:0]};
            `RENDER_MAP_256: map_idx = {vmap_wrapped, hmap_idx};
        endcase
    end

    // Two entries per word
    assign map_addr = {cfg.map_base, {`RENDER_BASE_SHIFT{1'b0}}} + map_idx[15:1];
    assign map_half = map_idx[0];
    assign tile_row = scrolled_line[2:0];
    assign col_odd  = hmap_idx[0];      // Last entry of this map word

endmodule

//--- pixel_emit.sv
`include "render_cfg.svh"

module pixel_emit (
    input  logic                        clk,
    input  logic                        rst,
    input  render_pkg::layer_cfg_t      cfg,
    input  logic                        line_start,
    input  logic                        render_start,
    input  render_pkg::render_word_t    render_word,
    output logic                        busy,
    output logic                        line_done,

    // Line buffer
    output logic                        lb_wren,
    output logic [`RENDER_LB_IDX_W-1:0] lb_wridx,
    output logic [7:0]                  lb_wrdata
);

    import render_pkg::*;

    localparam logic [`RENDER_LB_IDX_W-1:0] LINE_END = `RENDER_LINE_PIXELS;

    render_word_t                word_r;
    logic [2:0]                  xcnt_r;        // Pixel within word
    logic                        busy_r;
    logic [`RENDER_LB_IDX_W-1:0] wridx_r;
    logic [`RENDER_LB_IDX_W-1:0] start_idx;
    logic                        is_8bpp;
    logic                        last_pix;
    logic [2:0]                  pix_sel;
    logic [3:0]                  pix_4bpp;
    logic [7:0]                  pix_8bpp;
    logic [7:0]                  pix_raw;
    logic                        use_pal;

    assign is_8bpp  = (cfg.depth == DEPTH_8BPP);
    assign last_pix = is_8bpp ? (xcnt_r == 3'd3) : (xcnt_r == 3'd7);

    // First pixels of a fine scroll land below zero and wrap out of view
    assign start_idx = '0 - {{(`RENDER_LB_IDX_W - 3){1'b0}}, cfg.hscroll[2:0]};

    // 640 is 5 * 128 and negative start indices have all top bits set
    assign line_done = (wridx_r[`RENDER_LB_IDX_W-1:7] == LINE_END[`RENDER_LB_IDX_W-1:7]);

    ///////////////////////////////
    // Pixel select
    ///////////////////////////////

    assign pix_sel = word_r.hflip ? ~xcnt_r : xcnt_r;

    // Even pixel in the high nibble
    assign pix_4bpp = word_r.pixels[{pix_sel[2:1], ~pix_sel[0], 2'b00} +: 4];
    assign pix_8bpp = word_r.pixels[{pix_sel[1:0], 3'b000} +: 8];
    assign pix_raw  = is_8bpp ? pix_8bpp : {4'b0000, pix_4bpp};

    // Offset only colors 1 to 15
    assign use_pal  = (pix_raw[7:4] == 4'd0) && (pix_raw[3:0] != 4'd0);

    assign lb_wrdata = {use_pal ? word_r.pal_offset : pix_raw[7:4], pix_raw[3:0]};
    assign lb_wridx  = wridx_r;
    assign lb_wren   = busy_r && !line_done;

    // Free during the last pixel so words run back to back
    assign busy = busy_r && !last_pix;

    ///////////////////////////////
    // Counters
    ///////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_r  <= 1'b0;
            xcnt_r  <= '0;
            wridx_r <= '0;
        end else if (line_start) begin
            busy_r  <= 1'b0;
            xcnt_r  <= '0;
            wridx_r <= start_idx;
        end else if (render_start) begin
            busy_r <= 1'b1;
            xcnt_r <= '0;
        end else if (busy_r) begin
            if (line_done) begin
                busy_r <= 1'b0;           // Rest of the word is off screen
            end else begin
                wridx_r <= wridx_r + 1'b1;
                xcnt_r  <= last_pix ? 3'd0 : xcnt_r + 3'd1;
                busy_r  <= !last_pix;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (render_start) word_r <= render_word;
    end

    // Writes stay on screen or in the fine scroll lead-in below zero
    a_done_quiet: assert property (@(posedge clk) disable iff (rst)
        lb_wren |-> (lb_wridx < LINE_END) || (&lb_wridx[`RENDER_LB_IDX_W-1:3]))
        else $error("line buffer write past line end");

endmodule

//--- render_cfg.svh
`ifndef RENDER_CFG_SVH
`define RENDER_CFG_SVH

// Video memory bus
`define RENDER_ADDR_W       15      // Word address
`define RENDER_DATA_W       32

// Line buffer
`define RENDER_LINE_PIXELS  640
`define RENDER_LB_IDX_W     10

// Base registers count in 128-word units
`define RENDER_BASE_SHIFT   7

// Map width and height codes
`define RENDER_MAP_32       2'd0
`define RENDER_MAP_64       2'd1
`define RENDER_MAP_128      2'd2
`define RENDER_MAP_256      2'd3

`endif

//--- render_pkg.sv
`include "render_cfg.svh"

package render_pkg;

    // Color depth, codes 0 and 1 render as 4bpp
    typedef enum logic [1:0] {
        DEPTH_4BPP = 2'd2,
        DEPTH_8BPP = 2'd3
    } depth_e;

    typedef enum logic [2:0] {
        WAIT_START = 3'd0,
        FETCH_MAP  = 3'd1,
        WAIT_MAP   = 3'd2,
        FETCH_TILE = 3'd3,
        WAIT_TILE  = 3'd4,
        RENDER     = 3'd5
    } fetch_state_e;

    // Layer registers
    typedef struct packed {
        depth_e      depth;
        logic [1:0]  map_height;     // Map size code
        logic [1:0]  map_width;
        logic [7:0]  map_base;
        logic [7:0]  tile_base;
        logic [11:0] hscroll;
        logic [11:0] vscroll;
        logic [1:0]  pad;
    } layer_cfg_t;

    // One half of a map word
    typedef struct packed {
        logic [3:0] pal_offset;
        logic       vflip;
        logic       hflip;
        logic [9:0] tile_idx;
    } map_entry_t;

    // Tile word on its way to the pixel stage
    typedef struct packed {
        logic [`RENDER_DATA_W-1:0] pixels;
        logic [3:0]                pal_offset;
        logic                      hflip;
    } render_word_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the layer renderer testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_layer_renderer \
    --Mdir obj_dir -o tb_layer_renderer
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_layer_renderer
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

//--- sim.f
+incdir+.
render_pkg.sv
map_addr_calc.sv
tile_addr_calc.sv
fetch_seq.sv
pixel_emit.sv
layer_renderer.sv
tb_clock.sv
tb_layer_renderer.sv

//--- tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam real HALF_PERIOD  = 10.0;    // 20 ns clock
    localparam int  RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- tb_layer_renderer.sv
`include "render_cfg.svh"

module tb_layer_renderer;

    timeunit 1ns;
    timeprecision 100ps;

    import render_pkg::*;

    localparam int MEM_WORDS      = 1 << `RENDER_ADDR_W;
    localparam int IDLE_LIMIT     = 64;       // Quiet cycles that close a line
    // Six lines of roughly 2000 cycles each at worst bus latency, plus margin
    localparam int TIMEOUT_CYCLES = 40000;

    logic                        clk;
    logic                        rst;
    layer_cfg_t                  cfg;
    logic [8:0]                  line_idx;
    logic                        line_start;
    logic [`RENDER_ADDR_W-1:0]   bus_addr;
    logic                        bus_strobe;
    logic [`RENDER_DATA_W-1:0]   bus_rddata = '0;
    logic                        bus_ack = 1'b0;
    logic                        lb_wren;
    logic [`RENDER_LB_IDX_W-1:0] lb_wridx;
    logic [7:0]                  lb_wrdata;

    integer                      seed = 32'h36bc_be2d;
    logic [`RENDER_DATA_W-1:0]   mem [MEM_WORDS];
    logic [7:0]                  line_pix [`RENDER_LINE_PIXELS];
    logic                        written [`RENDER_LINE_PIXELS];
    logic                        wrote_any = 1'b0;
    int                          idle_cnt = 0;
    int                          cycles = 0;
    logic                        ack_pending = 1'b0;
    int                          ack_wait = 0;

    tb_clock u_clock (
        .clk (clk),
        .rst (rst)
    );

    layer_renderer uut (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .line_idx   (line_idx),
        .line_start (line_start),
        .bus_addr   (bus_addr),
        .bus_strobe (bus_strobe),
        .bus_rddata (bus_rddata),
        .bus_ack    (bus_ack),
        .lb_wren    (lb_wren),
        .lb_wridx   (lb_wridx),
        .lb_wrdata  (lb_wrdata)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    ///////////////////////////////
    // Memory model and checker
    ///////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            bus_ack     <= 1'b0;
            ack_pending <= 1'b0;
        end else if (bus_ack) begin
            bus_ack <= 1'b0;                     // Strobe is masked in this cycle
        end else if (ack_pending) begin
            if (ack_wait == 0) begin
                bus_ack     <= 1'b1;
                bus_rddata  <= mem[bus_addr];
                ack_pending <= 1'b0;
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end else if (bus_strobe) begin
            ack_pending <= 1'b1;
            ack_wait    <= $random(seed) & 3;   // Ack 1 to 4 cycles later
        end
    end

    always @(negedge clk) begin
        if (line_start) begin
            for (int i = 0; i < `RENDER_LINE_PIXELS; i++) begin
                written[i] = 1'b0;
            end
            wrote_any = 1'b0;
            idle_cnt  = 0;
        end else if (lb_wren) begin
            // Fine scroll lead-in lands above 639
            if (lb_wridx < `RENDER_LINE_PIXELS) begin
                line_pix[lb_wridx] = lb_wrdata;
                written[lb_wridx]  = 1'b1;
            end
            wrote_any = 1'b1;
            idle_cnt  = 0;
        end else if (wrote_any) begin
            idle_cnt = idle_cnt + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_error($sformatf("Timeout after %0d cycles, line never finished", cycles));
        end
    end

    ///////////////////////////////
    // Reference pixel model
    ///////////////////////////////

    function automatic logic [7:0] expected_pixel(input layer_cfg_t c, input int line,
                                                  input int x);
        int          sx;
        int          sy;
        int          width;
        int          height;
        int          idx;
        int          prow;
        int          pcol;
        int          addr;
        logic [31:0] word;
        logic [15:0] ent;
        logic [7:0]  pix;

        sx     = x + int'(c.hscroll);
        sy     = line + int'(c.vscroll);
        width  = 32 << c.map_width;
        height = 32 << c.map_height;
        // Tile row and column are bits 10 to 3, wrapped by map size
        idx  = (((sy >> 3) & 255) % height) * width + (((sx >> 3) & 255) % width);
        word = mem[(int'(c.map_base) * 128 + idx / 2) % MEM_WORDS];
        ent  = (idx % 2 == 1) ? word[31:16] : word[15:0];
        prow = ent[11] ? 7 - (sy & 7) : (sy & 7);     // vflip
        pcol = ent[10] ? 7 - (sx & 7) : (sx & 7);     // hflip
        if (c.depth == DEPTH_8BPP) begin
            addr = int'(c.tile_base) * 128 + int'(ent[9:0]) * 16 + prow * 2 + pcol / 4;
            word = mem[addr % MEM_WORDS];
            pix  = word[8 * (pcol % 4) +: 8];
        end else begin
            addr = int'(c.tile_base) * 128 + int'(ent[9:0]) * 8 + prow;
            word = mem[addr % MEM_WORDS];
            pix  = {4'h0, word[8 * (pcol / 2) + 4 * (1 - pcol % 2) +: 4]};   // Even pixel high
        end
        if (pix[7:4] == 4'h0 && pix[3:0] != 4'h0) begin
            pix[7:4] = ent[15:12];
        end
        return pix;
    endfunction

    function automatic layer_cfg_t make_cfg(input depth_e depth, input logic [1:0] width,
                                            input logic [1:0] height, input logic [7:0] mbase,
                                            input logic [7:0] tbase, input logic [11:0] hs,
                                            input logic [11:0] vs);
        layer_cfg_t c;

        c.depth      = depth;
        c.map_height = height;
        c.map_width  = width;
        c.map_base   = mbase;
        c.tile_base  = tbase;
        c.hscroll    = hs;
        c.vscroll    = vs;
        c.pad        = 2'b00;
        return c;
    endfunction

    ///////////////////////////////
    // Tests
    ///////////////////////////////

    task automatic render_line(input layer_cfg_t c, input int line);
        logic [7:0] exp;

        @(posedge clk);
        cfg        <= c;
        line_idx   <= line[8:0];
        line_start <= 1'b1;
        @(posedge clk);
        line_start <= 1'b0;
        while (!(wrote_any && idle_cnt >= IDLE_LIMIT)) begin
            @(posedge clk);
        end
        for (int x = 0; x < `RENDER_LINE_PIXELS; x++) begin
            exp = expected_pixel(c, line, x);
            assert (written[x])
                else report_error($sformatf("Pixel %0d of line %0d was never written",
                                            x, line));
            assert (line_pix[x] == exp)
                else report_error($sformatf(
                    "FAILED lb_wrdata at index %0d line %0d: 0x%02h, expected 0x%02h",
                    x, line, line_pix[x], exp));
        end
    endtask

    task automatic test_idle_after_reset();
        while (rst) begin
            @(posedge clk);
        end
        repeat (10) begin
            @(negedge clk);
            assert (!lb_wren && !bus_strobe)
                else report_error("Bus strobe or line buffer write seen before any line start");
        end
    endtask

    task automatic test_flip_palette();
        layer_cfg_t c;
        int         base;

        c    = make_cfg(DEPTH_8BPP, `RENDER_MAP_32, `RENDER_MAP_32, 8'h68, 8'h10,
                        12'h006, 12'h000);
        base = 32'h68 * 128;
        // hflip, vflip or both in every entry of the map
        for (int i = 0; i < 512; i++) begin
            case (i % 3)
                0:       mem[base + i] = mem[base + i] | 32'h0400_0400;
                1:       mem[base + i] = mem[base + i] | 32'h0800_0800;
                default: mem[base + i] = mem[base + i] | 32'h0C00_0C00;
            endcase
        end
        render_line(c, 40);
    endtask

    initial begin
        cfg        = make_cfg(DEPTH_4BPP, `RENDER_MAP_32, `RENDER_MAP_32, 8'h00, 8'h00,
                              12'h000, 12'h000);
        line_idx   = '0;
        line_start = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end

        test_idle_after_reset();

        // 4bpp, small map, no scroll
        render_line(make_cfg(DEPTH_4BPP, `RENDER_MAP_32, `RENDER_MAP_32, 8'h10, 8'h40,
                             12'h000, 12'h000), 0);
        render_line(make_cfg(DEPTH_4BPP, `RENDER_MAP_32, `RENDER_MAP_32, 8'h10, 8'h40,
                             12'h000, 12'h000), 13);

        // 8bpp, two words per tile row
        render_line(make_cfg(DEPTH_8BPP, `RENDER_MAP_64, `RENDER_MAP_32, 8'h20, 8'h80,
                             12'h000, 12'h000), 100);

        // Fine offset and map wrap
        render_line(make_cfg(DEPTH_4BPP, `RENDER_MAP_128, `RENDER_MAP_128, 8'h30, 8'h00,
                             12'h013, 12'h02F), 200);
        render_line(make_cfg(DEPTH_8BPP, `RENDER_MAP_128, `RENDER_MAP_128, 8'h30, 8'h00,
                             12'hFFD, 12'h02F), 77);

        test_flip_palette();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- tile_addr_calc.sv
`include "render_cfg.svh"

module tile_addr_calc (
    input  render_pkg::layer_cfg_t    cfg,
    input  logic [`RENDER_DATA_W-1:0] map_word,
    input  logic                      map_half,
    input  logic [2:0]                tile_row,
    input  logic                      word_cnt,
    output render_pkg::map_entry_t    entry,
    output logic [`RENDER_ADDR_W-1:0] tile_addr
);

    import render_pkg::*;

    logic [2:0]                row_flipped;
    logic                      word_flipped;
    logic [`RENDER_ADDR_W-1:0] tile_offset;

    // High half holds the odd column
    assign entry = map_half ? map_entry_t'(map_word[16 +: 16])
                            : map_entry_t'(map_word[0 +: 16]);

    assign row_flipped  = entry.vflip ? ~tile_row : tile_row;
    assign word_flipped = entry.hflip ? ~word_cnt : word_cnt;   // 8bpp only

    ///////////////////////////////
    // Pattern offset
    ///////////////////////////////

    always_comb begin
        if (cfg.depth == DEPTH_8BPP) begin
            // 16 words per tile, two per row
            tile_offset = {1'b0, entry.tile_idx, row_flipped, word_flipped};
        end else begin
            tile_offset = {2'b00, entry.tile_idx, row_flipped};    // 8 words per tile
        end
    end

    assign tile_addr = {cfg.tile_base, {`RENDER_BASE_SHIFT{1'b0}}} + tile_offset;

endmodule
